//--- hdl/rv32m_params.svh
`ifndef RV32M_PARAMS_SVH
`define RV32M_PARAMS_SVH

// ----------------------------------------
// Architectural widths
// ----------------------------------------

// Operand and result word
`define RV32M_XLEN 32

// Destination tag, one per outstanding command
`define RV32M_TAG_W 5

// ----------------------------------------
// Divider
// ----------------------------------------
`define RV32M_DIV_STEPS 32  // One quotient bit per step

`endif

//--- hdl/rv32m_pkg.sv
`include "rv32m_params.svh"

package rv32m_pkg;

    // Data words and tags
    typedef logic [`RV32M_XLEN-1:0] xlen_t;
    typedef logic [`RV32M_TAG_W-1:0] tag_t;

    // M-extension operation, value equals funct3
    typedef enum logic [2:0] {
        OP_MUL    = 3'd0,
        OP_MULH   = 3'd1,
        OP_MULHSU = 3'd2,
        OP_MULHU  = 3'd3,
        OP_DIV    = 3'd4,
        OP_DIVU   = 3'd5,
        OP_REM    = 3'd6,
        OP_REMU   = 3'd7
    } m_op_e;

    // Multiplier FSM
    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_EXEC,
        MUL_RET
    } mul_state_e;

    // Divider FSM
    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_CHECK,
        DIV_EXEC,
        DIV_RET
    } div_state_e;

endpackage

//--- hdl/muldiv_if.sv
`timescale 1ns/100ps

// ----------------------------------------
// Command channel, router to unit
// ----------------------------------------
interface muldiv_cmd_if;
    import rv32m_pkg::*;

    logic  valid;
    logic  ready;
    m_op_e op;
    xlen_t src1;
    xlen_t src2;
    tag_t  tag;

    modport issuer (
        output valid, op, src1, src2, tag,
        input  ready
    );

    modport unit (
        input  valid, op, src1, src2, tag,
        output ready
    );
endinterface

// ----------------------------------------
// Response channel, unit to router
// ----------------------------------------
interface muldiv_rsp_if;
    import rv32m_pkg::*;

    logic  valid;
    logic  ready;
    tag_t  tag;
    xlen_t result;

    modport source (
        output valid, tag, result,
        input  ready
    );

    modport sink (
        input  valid, tag, result,
        output ready
    );
endinterface

//--- hdl/muldiv_router.sv
`timescale 1ns/100ps

module muldiv_router (
    input  logic                clk_i,
    input  logic                arst_n_i,
    // Top-level command side
    input  logic                cmd_valid_i,
    output logic                cmd_ready_o,
    input  rv32m_pkg::m_op_e    cmd_op_i,
    input  rv32m_pkg::xlen_t    cmd_src1_i,
    input  rv32m_pkg::xlen_t    cmd_src2_i,
    input  rv32m_pkg::tag_t     cmd_tag_i,
    // Top-level response side
    output logic                rsp_valid_o,
    input  logic                rsp_ready_i,
    output rv32m_pkg::tag_t     rsp_tag_o,
    output rv32m_pkg::xlen_t    rsp_result_o,
    // Unit channels
    muldiv_cmd_if.issuer        mul_cmd,
    muldiv_cmd_if.issuer        div_cmd,
    muldiv_rsp_if.sink          mul_rsp,
    muldiv_rsp_if.sink          div_rsp
);
    import rv32m_pkg::*;

    logic  is_div;       // funct3[2] picks the divider
    logic  slot_load;
    logic  slot_valid_q;
    tag_t  slot_tag_q;
    xlen_t slot_result_q;

    // ----------------------------------------
    // Command steering
    // ----------------------------------------
    assign is_div = cmd_op_i[2];

    assign mul_cmd.valid = cmd_valid_i && !is_div;
    assign mul_cmd.op    = cmd_op_i;
    assign mul_cmd.src1  = cmd_src1_i;
    assign mul_cmd.src2  = cmd_src2_i;
    assign mul_cmd.tag   = cmd_tag_i;

    assign div_cmd.valid = cmd_valid_i && is_div;
    assign div_cmd.op    = cmd_op_i;
    assign div_cmd.src1  = cmd_src1_i;
    assign div_cmd.src2  = cmd_src2_i;
    assign div_cmd.tag   = cmd_tag_i;

    assign cmd_ready_o = is_div ? div_cmd.ready : mul_cmd.ready;

    // ----------------------------------------
    // Response arbitration and output slot
    // ----------------------------------------

    // Slot takes a new entry when empty or draining this cycle
    assign slot_load = !slot_valid_q || rsp_ready_i;

    assign div_rsp.ready = slot_load;
    assign mul_rsp.ready = slot_load && !div_rsp.valid;  // Divider has priority

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            slot_valid_q <= 1'b0;
        end else if (slot_load) begin
            slot_valid_q <= div_rsp.valid || mul_rsp.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (slot_load) begin
            if (div_rsp.valid) begin
                slot_tag_q    <= div_rsp.tag;
                slot_result_q <= div_rsp.result;
            end else begin
                slot_tag_q    <= mul_rsp.tag;
                slot_result_q <= mul_rsp.result;
            end
        end
    end

    assign rsp_valid_o  = slot_valid_q;
    assign rsp_tag_o    = slot_tag_q;
    assign rsp_result_o = slot_result_q;

    // A held response stays put until the consumer takes it
    a_rsp_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        rsp_valid_o && !rsp_ready_i |=>
            rsp_valid_o && $stable(rsp_tag_o) && $stable(rsp_result_o))
        else $error("router response dropped or changed without a transfer");

endmodule

//--- hdl/mul_unit.sv
`timescale 1ns/100ps
`include "rv32m_params.svh"

module mul_unit (
    input  logic         clk_i,
    input  logic         arst_n_i,
    muldiv_cmd_if.unit   cmd,
    muldiv_rsp_if.source rsp
);
    import rv32m_pkg::*;

    localparam int MSB = `RV32M_XLEN - 1;

    mul_state_e state;

    logic signed [`RV32M_XLEN:0]     mcand_q;   // Extended by one sign bit
    logic signed [`RV32M_XLEN:0]     mplier_q;
    logic        [2*`RV32M_XLEN-1:0] product_q;
    logic                            is_high_q;
    tag_t                            tag_q;

    logic accept;
    logic src1_signed;
    logic src2_signed;

    // MULH is signed x signed, MULHSU signed x unsigned
    assign src1_signed = (cmd.op == OP_MULH) || (cmd.op == OP_MULHSU);
    assign src2_signed = (cmd.op == OP_MULH);

    assign cmd.ready = (state == MUL_IDLE);
    assign accept    = cmd.valid && cmd.ready;

    // ----------------------------------------
    // FSM
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state <= MUL_IDLE;
        end else begin
            case (state)
                MUL_IDLE: if (accept) state <= MUL_EXEC;
                MUL_EXEC: state <= MUL_RET;
                MUL_RET:  if (rsp.ready) state <= MUL_IDLE;
                default:  state <= MUL_IDLE;
            endcase
        end
    end

    // Operand capture and the single multiply cycle
    always_ff @(posedge clk_i) begin
        if (accept) begin
            mcand_q   <= {src1_signed & cmd.src1[MSB], cmd.src1};
            mplier_q  <= {src2_signed & cmd.src2[MSB], cmd.src2};
            is_high_q <= (cmd.op != OP_MUL);
            tag_q     <= cmd.tag;
        end
        if (state == MUL_EXEC) begin
            product_q <= mcand_q * mplier_q;  // Low 64 bits of the 66-bit product
        end
    end

    assign rsp.valid  = (state == MUL_RET);
    assign rsp.tag    = tag_q;
    assign rsp.result = is_high_q ? product_q[2*`RV32M_XLEN-1:`RV32M_XLEN] : product_q[MSB:0];

    a_state_legal: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        state inside {MUL_IDLE, MUL_EXEC, MUL_RET})
        else $error("multiplier state illegal");

    // Captured command stays put until the unit is back in IDLE
    a_busy_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        state != MUL_IDLE |=> $stable(mcand_q) && $stable(mplier_q)
                              && $stable(is_high_q) && $stable(tag_q))
        else $error("multiplier took a command outside IDLE");

endmodule

//--- hdl/div_unit.sv
`timescale 1ns/100ps
`include "rv32m_params.svh"

module div_unit (
    input  logic         clk_i,
    input  logic         arst_n_i,
    muldiv_cmd_if.unit   cmd,
    muldiv_rsp_if.source rsp
);
    import rv32m_pkg::*;

    localparam int MSB   = `RV32M_XLEN - 1;
    localparam int CNT_W = $clog2(`RV32M_DIV_STEPS);

    div_state_e       state;
    logic [CNT_W-1:0] cntr;

    xlen_t remainder_q;
    xlen_t quotient_q;
    xlen_t divisor_q;
    logic  is_rem_q;
    logic  dvs_neg_q;   // Divisor negative
    logic  quo_neg_q;   // Quotient to be negated in RET
    logic  rem_neg_q;   // Remainder follows the dividend sign
    tag_t  tag_q;

    logic                  accept;
    logic                  signed_op;
    logic                  step_ok;
    logic [`RV32M_XLEN:0]   shifted;
    logic [`RV32M_XLEN+1:0] diff;
    xlen_t                 dvd_mag;
    xlen_t                 dvs_mag;

    assign cmd.ready = (state == DIV_IDLE);
    assign accept    = cmd.valid && cmd.ready;
    assign signed_op = (cmd.op == OP_DIV) || (cmd.op == OP_REM);

    // Magnitudes for the unsigned core
    assign dvd_mag = rem_neg_q ? -remainder_q : remainder_q;
    assign dvs_mag = dvs_neg_q ? -divisor_q : divisor_q;

    // ----------------------------------------
    // One restoring step
    // ----------------------------------------

    // Keep the full 33-bit partial remainder, divisors above 2^31 need it
    assign shifted = {remainder_q, quotient_q[MSB]};
    assign diff    = {1'b0, shifted} - {2'b00, divisor_q};
    assign step_ok = !diff[`RV32M_XLEN+1];  // No borrow, subtract sticks

    // ----------------------------------------
    // FSM and step counter
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state <= DIV_IDLE;
            cntr  <= '0;
        end else begin
            case (state)
                DIV_IDLE: if (accept) state <= DIV_CHECK;
                DIV_CHECK: begin
                    cntr <= CNT_W'(`RV32M_DIV_STEPS - 1);
                    if (divisor_q == '0) begin
                        state <= DIV_RET;  // Divide by zero skips EXEC
                    end else begin
                        state <= DIV_EXEC;
                    end
                end
                DIV_EXEC: begin
                    cntr <= cntr - 1'b1;
                    if (cntr == '0) state <= DIV_RET;
                end
                DIV_RET: if (rsp.ready) state <= DIV_IDLE;
                default: state <= DIV_IDLE;
            endcase
        end
    end

    // Datapath
    always_ff @(posedge clk_i) begin
        case (state)
            DIV_IDLE: begin
                if (accept) begin
                    is_rem_q    <= cmd.op[1];  // REM, REMU
                    dvs_neg_q   <= signed_op & cmd.src2[MSB];
                    quo_neg_q   <= signed_op & (cmd.src1[MSB] ^ cmd.src2[MSB]);
                    rem_neg_q   <= signed_op & cmd.src1[MSB];
                    divisor_q   <= cmd.src2;
                    remainder_q <= cmd.src1;
                    quotient_q  <= '0;
                    tag_q       <= cmd.tag;
                end
            end
            DIV_CHECK: begin
                if (divisor_q == '0) begin
                    // All-ones quotient, raw dividend as remainder
                    quo_neg_q  <= 1'b0;
                    rem_neg_q  <= 1'b0;
                    quotient_q <= '1;
                end else begin
                    divisor_q   <= dvs_mag;
                    remainder_q <= '0;
                    quotient_q  <= dvd_mag;  // Shifted out MSB first
                end
            end
            DIV_EXEC: begin
                if (step_ok) begin
                    remainder_q <= diff[MSB:0];
                    quotient_q  <= {quotient_q[MSB-1:0], 1'b1};
                end else begin
                    remainder_q <= shifted[MSB:0];
                    quotient_q  <= {quotient_q[MSB-1:0], 1'b0};
                end
            end
            default: ;  // RET holds the payload
        endcase
    end

    assign rsp.valid  = (state == DIV_RET);
    assign rsp.tag    = tag_q;
    assign rsp.result = is_rem_q ? (rem_neg_q ? -remainder_q : remainder_q)
                                 : (quo_neg_q ? -quotient_q : quotient_q);

    // Counter moves only when loaded in CHECK or stepping in EXEC
    a_cntr_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(state inside {DIV_CHECK, DIV_EXEC}) |=> $stable(cntr))
        else $error("divider step counter moved outside EXEC");

    a_rsp_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        rsp.valid && !rsp.ready |=> rsp.valid && $stable(rsp.result) && $stable(rsp.tag))
        else $error("divider response changed while held");

endmodule

//--- hdl/rv32m_unit.sv
`timescale 1ns/100ps

module rv32m_unit (
    input  logic             clk_i,
    input  logic             arst_n_i,
    // Command
    input  logic             cmd_valid_i,
    output logic             cmd_ready_o,
    input  rv32m_pkg::m_op_e cmd_op_i,
    input  rv32m_pkg::xlen_t cmd_src1_i,
    input  rv32m_pkg::xlen_t cmd_src2_i,
    input  rv32m_pkg::tag_t  cmd_tag_i,
    // Response
    output logic             rsp_valid_o,
    input  logic             rsp_ready_i,
    output rv32m_pkg::tag_t  rsp_tag_o,
    output rv32m_pkg::xlen_t rsp_result_o
);

    // ----------------------------------------
    // Internal channels
    // ----------------------------------------
    muldiv_cmd_if mul_cmd_bus ();
    muldiv_cmd_if div_cmd_bus ();
    muldiv_rsp_if mul_rsp_bus ();
    muldiv_rsp_if div_rsp_bus ();

    muldiv_router u_router (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_ready_o  (cmd_ready_o),
        .cmd_op_i     (cmd_op_i),
        .cmd_src1_i   (cmd_src1_i),
        .cmd_src2_i   (cmd_src2_i),
        .cmd_tag_i    (cmd_tag_i),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_ready_i  (rsp_ready_i),
        .rsp_tag_o    (rsp_tag_o),
        .rsp_result_o (rsp_result_o),
        .mul_cmd      (mul_cmd_bus),
        .div_cmd      (div_cmd_bus),
        .mul_rsp      (mul_rsp_bus),
        .div_rsp      (div_rsp_bus)
    );

    // Both units run concurrently
    mul_unit u_mul (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .cmd      (mul_cmd_bus),
        .rsp      (mul_rsp_bus)
    );

    div_unit u_div (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .cmd      (div_cmd_bus),
        .rsp      (div_rsp_bus)
    );

endmodule

//--- testbench/tb_rv32m_unit.sv
`timescale 1ns/100ps

module tb_rv32m_unit;
    import rv32m_pkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 4;
    localparam int N_CMDS          = 400;
    localparam int N_TAGS          = 1 << $bits(tag_t);
    localparam int WATCHDOG_CYCLES = N_CMDS * 40 + 500;  // Slack for reset and drain

    logic  clk_i = 1'b0;
    logic  arst_n_i;
    logic  cmd_valid_i;
    logic  cmd_ready_o;
    m_op_e cmd_op_i;
    xlen_t cmd_src1_i;
    xlen_t cmd_src2_i;
    tag_t  cmd_tag_i;
    logic  rsp_valid_o;
    logic  rsp_ready_i;
    tag_t  rsp_tag_o;
    xlen_t rsp_result_o;

    // Model state, indexed by tag
    xlen_t exp_result [N_TAGS];
    bit    outstanding [N_TAGS];
    int    issue_seq [N_TAGS];

    logic [31:0] rng_state = 32'hb13d_22f0;
    int    issued = 0;
    int    answered = 0;
    int    mismatch_errs = 0;
    int    other_errs = 0;
    int    out_of_order = 0;
    logic  cmd_fire = 1'b0;
    logic  held_valid = 1'b0;   // Response seen valid but not taken
    tag_t  held_tag;
    xlen_t held_result;

    rv32m_unit DUT (.*);

    initial begin : clock_gen
        forever #(CLK_PERIOD/2) clk_i = ~clk_i;
    end

    // ----------------------------------------
    // Random source and operand choice
    // ----------------------------------------
    function automatic logic [31:0] rand_word();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic xlen_t pick_operand();
        logic [31:0] r;
        logic [31:0] v;
        r = rand_word();
        v = rand_word();
        case (r[2:0])
            3'd0:    return '0;
            3'd1:    return '1;
            3'd2:    return 32'h8000_0000;
            3'd3:    return {28'h0, v[3:0]};         // Small positive
            3'd4:    return {28'hfff_ffff, v[3:0]};  // Small negative
            default: return v;
        endcase
    endfunction

    function automatic tag_t free_tag();
        logic [31:0] r;
        tag_t        t;
        r = rand_word();
        t = r[$bits(tag_t)-1:0];
        for (int i = 0; i < N_TAGS; i++) begin
            if (!outstanding[t]) return t;
            t = t + 1'b1;
        end
        return t;
    endfunction

    // ----------------------------------------
    // Reference model, RISC-V M semantics
    // ----------------------------------------
    function automatic xlen_t model_result(input m_op_e op, input xlen_t a, input xlen_t b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic        [63:0] ua;
        logic        [63:0] ub;
        logic        [63:0] res;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ua = {32'h0, a};
        ub = {32'h0, b};
        if (op[2] && b == '0) begin
            return op[1] ? a : '1;  // Remainder keeps the dividend
        end
        case (op)
            OP_MUL:    res = ua * ub;
            OP_MULH:   res = (sa * sb) >> 32;
            OP_MULHSU: res = (sa * ub) >> 32;
            OP_MULHU:  res = (ua * ub) >> 32;
            OP_DIV:    res = sa / sb;   // 64-bit math, overflow case wraps to 0x80000000
            OP_DIVU:   res = ua / ub;
            OP_REM:    res = sa % sb;
            default:   res = ua % ub;
        endcase
        return res[31:0];
    endfunction

    // ----------------------------------------
    // Stimulus and checks
    // ----------------------------------------
    task automatic set_cmd(input m_op_e op, input xlen_t a, input xlen_t b);
        cmd_op_i   = op;
        cmd_src1_i = a;
        cmd_src2_i = b;
    endtask

    task automatic new_command(input int idx);
        logic [31:0] r;
        r = rand_word();
        case (idx)  // Corner cases first, then random
            0:       set_cmd(OP_DIV, 32'h8000_0000, 32'hffff_ffff);
            1:       set_cmd(OP_REM, 32'h8000_0000, 32'hffff_ffff);
            2:       set_cmd(OP_DIVU, 32'h1234_5678, 32'h0);
            3:       set_cmd(OP_REMU, 32'h1234_5678, 32'h0);
            4:       set_cmd(OP_DIV, 32'h8765_4321, 32'h0);
            5:       set_cmd(OP_REM, 32'h8765_4321, 32'h0);
            6:       set_cmd(OP_MULH, 32'h8000_0000, 32'h8000_0000);
            7:       set_cmd(OP_MULHSU, 32'hffff_ffff, 32'hffff_ffff);
            8:       set_cmd(OP_MULHU, 32'hffff_ffff, 32'hffff_ffff);
            9:       set_cmd(OP_MUL, 32'h8000_0000, 32'hffff_ffff);
            default: set_cmd(m_op_e'(r[2:0]), pick_operand(), pick_operand());
        endcase
        cmd_tag_i   = free_tag();
        cmd_valid_i = 1'b1;
    endtask

    task automatic drive_cycle();
        logic [31:0] r;
        if (cmd_fire) begin
            cmd_valid_i = 1'b0;
        end
        r = rand_word();
        if (!cmd_valid_i && issued < N_CMDS && r[1:0] != 2'b00) begin
            new_command(issued);
        end
        r = rand_word();
        rsp_ready_i = (r[3:0] < 4'd11);  // Roughly 70 percent
    endtask

    task automatic check_response();
        bit older;
        older = 1'b0;
        assert (outstanding[rsp_tag_o]) else begin
            $display("response returned for tag %h which is not outstanding", rsp_tag_o);
            other_errs++;
        end
        if (outstanding[rsp_tag_o]) begin
            assert (rsp_result_o == exp_result[rsp_tag_o]) else begin
                $display("mismatch rsp_result_o (tag %h): got %h expected %h",
                         rsp_tag_o, rsp_result_o, exp_result[rsp_tag_o]);
                mismatch_errs++;
            end
            for (int t = 0; t < N_TAGS; t++) begin
                if (outstanding[t] && issue_seq[t] < issue_seq[rsp_tag_o]) older = 1'b1;
            end
            if (older) out_of_order++;
            outstanding[rsp_tag_o] = 1'b0;
        end
        answered++;
    endtask

    // Called mid-cycle, the coming rising edge does the transfers seen here
    task automatic sample_cycle();
        if (held_valid) begin
            assert (rsp_valid_o) else begin
                $display("response valid dropped before the response was taken");
                other_errs++;
            end
            assert (rsp_tag_o == held_tag) else begin
                $display("mismatch rsp_tag_o: got %h expected %h", rsp_tag_o, held_tag);
                mismatch_errs++;
            end
            assert (rsp_result_o == held_result) else begin
                $display("mismatch rsp_result_o: got %h expected %h", rsp_result_o, held_result);
                mismatch_errs++;
            end
        end
        if (rsp_valid_o && rsp_ready_i) check_response();
        held_valid  = rsp_valid_o && !rsp_ready_i;
        held_tag    = rsp_tag_o;
        held_result = rsp_result_o;
        cmd_fire    = cmd_valid_i && cmd_ready_o;
        if (cmd_fire) begin
            exp_result[cmd_tag_i]  = model_result(cmd_op_i, cmd_src1_i, cmd_src2_i);
            outstanding[cmd_tag_i] = 1'b1;
            issue_seq[cmd_tag_i]   = issued;
            issued++;
        end
    endtask

    initial begin : stimulus
        arst_n_i    = 1'b0;
        cmd_valid_i = 1'b0;
        cmd_op_i    = OP_MUL;
        cmd_src1_i  = '0;
        cmd_src2_i  = '0;
        cmd_tag_i   = '0;
        rsp_ready_i = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk_i);
        arst_n_i = 1'b1;
        #(CLK_PERIOD/4);
        assert (!rsp_valid_o) else begin
            $display("response valid is high right after reset");
            other_errs++;
        end
        assert (cmd_ready_o) else begin
            $display("command ready is low right after reset");
            other_errs++;
        end

        while (answered < N_CMDS) begin
            @(negedge clk_i);
            drive_cycle();
            #(CLK_PERIOD/4);
            sample_cycle();
        end

        for (int t = 0; t < N_TAGS; t++) begin
            assert (!outstanding[t]) else begin
                $display("command with tag %h was never answered", t);
                other_errs++;
            end
        end
        assert (issued == N_CMDS) else begin
            $display("only %0d of %0d commands were accepted", issued, N_CMDS);
            other_errs++;
        end
        assert (out_of_order > 0) else begin
            $display("no response ever overtook an older command");
            other_errs++;
        end

        $display("errors: mismatch %0d, other %0d", mismatch_errs, other_errs);
        if (mismatch_errs == 0 && other_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // ----------------------------------------
    // Watchdog
    // ----------------------------------------
    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout with %0d of %0d commands answered", answered, N_CMDS);
        $display("errors: mismatch %0d, other %0d", mismatch_errs, other_errs + 1);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- rv32m_unit.f
+incdir+hdl
hdl/rv32m_pkg.sv
hdl/muldiv_if.sv
hdl/muldiv_router.sv
hdl/mul_unit.sv
hdl/div_unit.sv
hdl/rv32m_unit.sv
testbench/tb_rv32m_unit.sv

//--- Bender.yml
package:
  name: rv32m_unit

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv32m_pkg.sv
      - hdl/muldiv_if.sv
      - hdl/muldiv_router.sv
      - hdl/mul_unit.sv
      - hdl/div_unit.sv
      - hdl/rv32m_unit.sv
  - target: test
    files:
      - testbench/tb_rv32m_unit.sv
